/* tb.f */
logic/noc_flit_pkg.sv
logic/traffic_pkg.sv
logic/packet_source.sv
logic/inject_port.sv
logic/packet_checker.sv
logic/test_monitor.sv
logic/local_unit_top.sv
test/flit_checker.sv
test/tb_local_unit.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_local_unit
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)

/* test/tb_local_unit.sv */
`timescale 1ns/100ps

module tb_local_unit;
    import noc_flit_pkg::*;
    import traffic_pkg::*;

    localparam coord_t   cx         = 3'd3;  // x at the ring end so dst wraps
    localparam coord_t   cy         = 3'd1;
    localparam coord_t   cz         = 3'd3;
    localparam pattern_t pat        = diag3;
    localparam int       psize      = 4;
    localparam int       pnum       = 6;
    localparam int       pgap       = 2;
    localparam int       credits    = 4;
    localparam int       depth      = 8;
    localparam int       idle_limit = 20;
    localparam int       wait_limit = 2000;
    localparam int       rows       = 7;

    // what to wait for
    localparam int w_inject = 0;
    localparam int w_done   = 1;
    localparam int w_error  = 2;

    logic       clk;
    logic       rst;
    flit_t      inject_flit;
    logic       inject_valid;
    logic       inject_credit;
    flit_t      eject_flit;
    logic       eject_valid;
    logic       eject_credit;
    logic       done;
    logic       error;
    check_err_t error_code;
    cnt_t       rcvd_count;

    logic       row_check;
    check_err_t exp_code;
    int         exp_count;
    logic       exp_done;
    int         inject_total;
    int         flit_errs;
    int         credit_errs;
    int         status_errs;

    // each letter is one eject flit (H head, B body, T tail, S single)
    string      row_kinds [rows] = '{
        "HBBTHBBTHBBTHBBTHBBTHBBT",  // six good packets
        "SSSHBBTSHBBT",              // singles mixed with packets
        "HBBTHBT",                   // second packet short
        "HBBBT",                     // packet too long
        "HBBTB",                     // stray body
        "HBHBBT",                    // head inside a packet
        "HBBT"                       // stalls after the head
    };
    int         row_gap   [rows] = '{0, 1, 0, 0, 0, 0, 30};
    check_err_t row_code  [rows] = '{none, none, flit_missing, flit_wrong,
                                     flit_wrong, flit_missing, flit_timeout};
    int         row_count [rows] = '{6, 6, 1, 0, 1, 0, 0};

    int          cyc = 0;
    int          ej_credits = 1;
    int          due [$];            // cycles at which inject credits go back
    logic [19:0] lfsr = 20'd89220;
    logic        hung = 1'b0;

    local_unit_top #(
        .cur_x          (cx),
        .cur_y          (cy),
        .cur_z          (cz),
        .pattern        (pat),
        .packet_size    (psize),
        .packet_num     (pnum),
        .injection_gap  (pgap),
        .inject_credits (credits),
        .inject_depth   (depth),
        .flit_timeout   (idle_limit)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .inject_flit   (inject_flit),
        .inject_valid  (inject_valid),
        .inject_credit (inject_credit),
        .eject_flit    (eject_flit),
        .eject_valid   (eject_valid),
        .eject_credit  (eject_credit),
        .done          (done),
        .error         (error),
        .error_code    (error_code),
        .rcvd_count    (rcvd_count)
    );

    flit_checker #(
        .cur_x          (cx),
        .cur_y          (cy),
        .cur_z          (cz),
        .pattern        (pat),
        .packet_size    (psize),
        .packet_num     (pnum),
        .inject_credits (credits)
    ) u_check (
        .clk           (clk),
        .rst           (rst),
        .inject_flit   (inject_flit),
        .inject_valid  (inject_valid),
        .inject_credit (inject_credit),
        .eject_valid   (eject_valid),
        .eject_credit  (eject_credit),
        .done          (done),
        .error         (error),
        .error_code    (error_code),
        .rcvd_count    (rcvd_count),
        .row_check     (row_check),
        .exp_code      (exp_code),
        .exp_count     (exp_count),
        .exp_done      (exp_done),
        .inject_total  (inject_total),
        .flit_errs     (flit_errs),
        .credit_errs   (credit_errs),
        .status_errs   (status_errs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 20 and 17
    function automatic logic [19:0] lfsr_next(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    function automatic flit_t flit_of(input byte c);
        flit_t f;
        f = '0;
        case (c)
            "H":     f.kind = head;
            "B":     f.kind = body;
            "T":     f.kind = tail;
            default: f.kind = single;
        endcase
        if (f.kind == head || f.kind == single) begin
            f.dst_x = cx;  // addressed to this node
            f.dst_y = cy;
            f.dst_z = cz;
            f.hops  = 4'd1;
        end
        return f;
    endfunction

    function automatic logic cond_met(input int which);
        case (which)
            w_inject: return inject_total >= pnum * psize;
            w_done:   return done;
            default:  return error;
        endcase
    endfunction

    // one clock step with inputs 1 ns after the edge and the router credit model
    task automatic tick();
        int d;
        int b;
        @(posedge clk);
        #1;
        cyc++;
        if (eject_credit) ej_credits++;
        if (rst) begin
            due.delete();
            inject_credit = 1'b0;
        end else begin
            if (inject_valid) begin
                d = 0;
                for (b = 0; b < 2; b++) begin
                    lfsr = lfsr_next(lfsr);
                    d = d * 2 + int'(lfsr[0]);
                end
                due.push_back(cyc + 1 + d);  // flit leaves at the next edge
            end
            if (due.size() > 0 && due[0] <= cyc) begin
                inject_credit = 1'b1;
                void'(due.pop_front());
            end else begin
                inject_credit = 1'b0;
            end
        end
    endtask

    task automatic wait_until(input int which, input string what);
        int n;
        n = 0;
        while (!cond_met(which) && n < wait_limit) begin
            tick();
            n++;
        end
        if (!cond_met(which)) begin
            $display("timeout after %0d cycles waiting for %s", wait_limit, what);
            hung = 1'b1;
        end
    endtask

    task automatic run_row(input int r);
        string k;
        int    i;
        int    n;
        k = row_kinds[r];
        $display("row %0d: eject %s, gap %0d", r, k, row_gap[r]);
        rst         = 1'b1;
        eject_valid = 1'b0;
        for (n = 0; n < 8; n++) tick();
        rst        = 1'b0;
        ej_credits = 1;
        for (i = 0; i < k.len(); i++) begin
            n = 0;
            while (ej_credits == 0 && n < wait_limit) begin
                tick();
                n++;
            end
            if (ej_credits == 0) begin
                $display("timeout waiting for an eject credit in row %0d", r);
                hung = 1'b1;
                return;
            end
            eject_flit  = flit_of(k[i]);
            eject_valid = 1'b1;
            ej_credits--;
            tick();
            eject_valid = 1'b0;
            for (n = 0; n < row_gap[r]; n++) tick();
        end
        wait_until(w_inject, "all inject flits");
        if (hung) return;
        exp_code  = row_code[r];
        exp_count = row_count[r];
        exp_done  = (row_code[r] == none) && (row_count[r] == pnum);
        if (exp_done) begin
            wait_until(w_done, "done");
        end else if (exp_code != none) begin
            wait_until(w_error, "error");
        end
        if (hung) return;
        row_check = 1'b1;
        tick();
        row_check = 1'b0;
    endtask

    initial begin
        int r;
        rst           = 1'b1;
        inject_credit = 1'b0;
        eject_flit    = '0;
        eject_valid   = 1'b0;
        row_check     = 1'b0;
        exp_code      = none;
        exp_count     = 0;
        exp_done      = 1'b0;
        for (r = 0; r < rows && !hung; r++) begin
            run_row(r);
        end
        $display("closing: %0d flit errors, %0d credit errors, %0d status errors, %0d timeouts",
                 flit_errs, credit_errs, status_errs, int'(hung));
        if (!hung && flit_errs + credit_errs + status_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* test/flit_checker.sv */
`timescale 1ns/100ps

module flit_checker #(
    parameter noc_flit_pkg::coord_t  cur_x          = 3'd0,
    parameter noc_flit_pkg::coord_t  cur_y          = 3'd0,
    parameter noc_flit_pkg::coord_t  cur_z          = 3'd0,
    parameter traffic_pkg::pattern_t pattern        = traffic_pkg::nearest,
    parameter int                    packet_size    = 4,
    parameter int                    packet_num     = 6,
    parameter int                    inject_credits = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  noc_flit_pkg::flit_t     inject_flit,
    input  logic                    inject_valid,
    input  logic                    inject_credit,
    input  logic                    eject_valid,
    input  logic                    eject_credit,
    input  logic                    done,
    input  logic                    error,
    input  traffic_pkg::check_err_t error_code,
    input  traffic_pkg::cnt_t       rcvd_count,
    input  logic                    row_check,
    input  traffic_pkg::check_err_t exp_code,
    input  int                      exp_count,
    input  logic                    exp_done,
    output int                      inject_total,
    output int                      flit_errs,
    output int                      credit_errs,
    output int                      status_errs
);
    import noc_flit_pkg::*;
    import traffic_pkg::*;

    int   seen = 0;         // inject flits since reset
    int   outstanding = 0;  // flits the router has not freed yet
    int   n_flit = 0;
    int   n_credit = 0;
    int   n_status = 0;
    logic done_q = 1'b0;
    logic ev_q = 1'b0;      // eject_valid at the previous edge

    assign inject_total = seen;
    assign flit_errs    = n_flit;
    assign credit_errs  = n_credit;
    assign status_errs  = n_status;

    function automatic flit_t expect_flit(input int pkt, input int pos);
        flit_t f;
        f = '0;
        if (packet_size == 1) f.kind = single;
        else if (pos == 0) f.kind = head;
        else if (pos == packet_size - 1) f.kind = tail;
        else f.kind = body;
        if (pos == 0) begin
            f.dst_x = coord_t'((int'(cur_x) + 1) % XSIZE);
            f.dst_y = (pattern == diag3) ? coord_t'((int'(cur_y) + 1) % YSIZE) : cur_y;
            f.dst_z = (pattern == diag3) ? coord_t'((int'(cur_z) + 1) % ZSIZE) : cur_z;
            f.hops  = (pattern == diag3) ? 4'd3 : 4'd1;
            f.src_x = cur_x;
            f.src_y = cur_y;
            f.src_z = cur_z;
            f.seq   = 7'(pkt);
        end
        return f;
    endfunction

    task automatic status_error(input string what, input int got, input int want);
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, want);
        n_status++;
    endtask

    always @(posedge clk) begin : watch
        flit_t want;
        int    pkt;
        int    pos;
        if (rst) begin
            seen        = 0;
            outstanding = 0;
            done_q      = 1'b0;
            ev_q        = 1'b0;
        end else begin
            if (eject_credit !== ev_q) begin
                $display("ERR %0t: eject_credit is %b, expected %b", $time, eject_credit, ev_q);
                n_credit++;
            end
            ev_q = eject_valid;
            if (inject_valid) begin
                pkt  = seen / packet_size;
                pos  = seen % packet_size;
                want = expect_flit(pkt, pos);
                if (pkt >= packet_num) begin
                    $display("ERR %0t: extra inject flit %h", $time, inject_flit);
                    n_flit++;
                end else if (inject_flit !== want) begin
                    $display("ERR %0t: packet %0d flit %0d is %h, expected %h",
                             $time, pkt, pos, inject_flit, want);
                    n_flit++;
                end
                seen++;
            end
            outstanding = outstanding + int'(inject_valid) - int'(inject_credit);
            if (outstanding > inject_credits) begin
                $display("ERR %0t: %0d flits outstanding, limit %0d",
                         $time, outstanding, inject_credits);
                n_credit++;
            end
            if (done && !done_q && (error || int'(rcvd_count) != packet_num)) begin
                status_error("rcvd_count at done", int'(rcvd_count), packet_num);
            end
            done_q = done;
            if (row_check) begin
                if (error_code !== exp_code) status_error("error_code", error_code, exp_code);
                if (int'(rcvd_count) != exp_count) begin
                    status_error("rcvd_count", int'(rcvd_count), exp_count);
                end
                if (done !== exp_done) status_error("done", done, exp_done);
                if (error !== (exp_code != none)) begin
                    status_error("error", error, int'(exp_code != none));
                end
                if (seen != packet_num * packet_size) begin
                    $display("ERR %0t: %0d inject flits seen, expected %0d",
                             $time, seen, packet_num * packet_size);
                    n_flit++;
                end
            end
        end
    end

endmodule

/* logic/local_unit_top.sv */
`timescale 1ns/100ps

module local_unit_top #(
    parameter noc_flit_pkg::coord_t  cur_x          = 3'd0,
    parameter noc_flit_pkg::coord_t  cur_y          = 3'd0,
    parameter noc_flit_pkg::coord_t  cur_z          = 3'd0,
    parameter traffic_pkg::pattern_t pattern        = traffic_pkg::nearest,
    parameter int                    packet_size    = 4,
    parameter int                    packet_num     = 6,
    parameter int                    injection_gap  = 2,
    parameter int                    inject_credits = 4,
    parameter int                    inject_depth   = 8,
    parameter int                    flit_timeout   = 20
) (
    input  logic                    clk,
    input  logic                    rst,
    output noc_flit_pkg::flit_t     inject_flit,
    output logic                    inject_valid,
    input  logic                    inject_credit,
    input  noc_flit_pkg::flit_t     eject_flit,
    input  logic                    eject_valid,
    output logic                    eject_credit,
    output logic                    done,
    output logic                    error,
    output traffic_pkg::check_err_t error_code,
    output traffic_pkg::cnt_t       rcvd_count
);
    import noc_flit_pkg::*;
    import traffic_pkg::*;

    flit_t      gen_flit;
    logic       gen_valid;
    logic       gen_full;
    cnt_t       sent_count;
    logic       src_done;
    logic       chk_error;
    check_err_t chk_code;

    // generator feeding the credit-controlled inject queue
    packet_source #(
        .cur_x         (cur_x),
        .cur_y         (cur_y),
        .cur_z         (cur_z),
        .pattern       (pattern),
        .packet_size   (packet_size),
        .packet_num    (packet_num),
        .injection_gap (injection_gap)
    ) u_source (
        .clk        (clk),
        .rst        (rst),
        .gen_full   (gen_full),
        .gen_flit   (gen_flit),
        .gen_valid  (gen_valid),
        .sent_count (sent_count),
        .src_done   (src_done)
    );

    inject_port #(
        .inject_credits (inject_credits),
        .inject_depth   (inject_depth)
    ) u_inject (
        .clk           (clk),
        .rst           (rst),
        .gen_flit      (gen_flit),
        .gen_valid     (gen_valid),
        .gen_full      (gen_full),
        .inject_flit   (inject_flit),
        .inject_valid  (inject_valid),
        .inject_credit (inject_credit)
    );

    packet_checker #(
        .packet_size  (packet_size),
        .flit_timeout (flit_timeout)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .eject_flit   (eject_flit),
        .eject_valid  (eject_valid),
        .eject_credit (eject_credit),
        .rcvd_count   (rcvd_count),
        .chk_error    (chk_error),
        .chk_code     (chk_code)
    );

    test_monitor #(
        .packet_num (packet_num)
    ) u_monitor (
        .clk        (clk),
        .rst        (rst),
        .sent_count (sent_count),
        .rcvd_count (rcvd_count),
        .src_done   (src_done),
        .chk_error  (chk_error),
        .chk_code   (chk_code),
        .done       (done),
        .error      (error),
        .error_code (error_code)
    );

endmodule

/* logic/test_monitor.sv */
`timescale 1ns/100ps

module test_monitor #(
    parameter int packet_num = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  traffic_pkg::cnt_t       sent_count,
    input  traffic_pkg::cnt_t       rcvd_count,
    input  logic                    src_done,
    input  logic                    chk_error,
    input  traffic_pkg::check_err_t chk_code,
    output logic                    done,
    output logic                    error,
    output traffic_pkg::check_err_t error_code
);
    import traffic_pkg::*;

    logic all_rcvd;

    assign all_rcvd = (rcvd_count == cnt_t'(packet_num));

    always_ff @(posedge clk) begin
        if (rst) begin
            done       <= 1'b0;
            error      <= 1'b0;
            error_code <= none;
        end else begin
            error      <= chk_error;
            error_code <= chk_code;
            if (src_done && all_rcvd && !chk_error) begin
                done <= 1'b1;  // stays set
            end
        end
    end

    // source stops at packet_num whatever the back-pressure
    a_sent_limit: assert property (@(posedge clk) disable iff (rst)
        sent_count <= cnt_t'(packet_num));

endmodule

/* logic/packet_checker.sv */
`timescale 1ns/100ps

module packet_checker #(
    parameter int packet_size  = 4,
    parameter int flit_timeout = 20
) (
    input  logic                    clk,
    input  logic                    rst,
    input  noc_flit_pkg::flit_t     eject_flit,
    input  logic                    eject_valid,
    output logic                    eject_credit,
    output traffic_pkg::cnt_t       rcvd_count,
    output logic                    chk_error,
    output traffic_pkg::check_err_t chk_code
);
    import noc_flit_pkg::*;
    import traffic_pkg::*;

    localparam int tw = $clog2(flit_timeout + 2);

    typedef enum logic [1:0] {
        st_idle,
        st_receiving,
        st_error
    } state_t;

    state_t        state;
    cnt_t          flit_cnt;  // flits seen in the current packet
    logic [tw-1:0] idle_cnt;

    assign chk_error = (state == st_error);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            flit_cnt     <= '0;
            idle_cnt     <= '0;
            rcvd_count   <= '0;
            chk_code     <= none;
            eject_credit <= 1'b0;
        end else begin
            eject_credit <= eject_valid;  // every flit is consumed so its slot frees at once
            case (state)
                st_idle: begin
                    if (eject_valid) begin
                        case (eject_flit.kind)
                            head: begin
                                state    <= st_receiving;
                                flit_cnt <= cnt_t'(1);
                                idle_cnt <= '0;
                            end
                            single: rcvd_count <= rcvd_count + 1'b1;
                            default: begin
                                state    <= st_error;
                                chk_code <= flit_wrong;
                            end
                        endcase
                    end
                end
                st_receiving: begin
                    if (eject_valid) begin
                        idle_cnt <= '0;
                        case (eject_flit.kind)
                            body: flit_cnt <= flit_cnt + 1'b1;
                            tail: begin
                                flit_cnt <= '0;
                                if (flit_cnt < cnt_t'(packet_size - 1)) begin
                                    state    <= st_error;
                                    chk_code <= flit_missing;  // packet too short
                                end else if (flit_cnt >= cnt_t'(packet_size)) begin
                                    state    <= st_error;
                                    chk_code <= flit_wrong;    // packet too long
                                end else begin
                                    state      <= st_idle;
                                    rcvd_count <= rcvd_count + 1'b1;
                                end
                            end
                            default: begin
                                // new packet started before the tail
                                state    <= st_error;
                                chk_code <= flit_missing;
                            end
                        endcase
                    end else if (idle_cnt == tw'(flit_timeout)) begin
                        state    <= st_error;
                        chk_code <= traffic_pkg::flit_timeout;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                default: state <= st_error;  // sticky until reset
            endcase
        end
    end

endmodule

/* logic/inject_port.sv */
`timescale 1ns/100ps

module inject_port #(
    parameter int inject_credits = 4,
    parameter int inject_depth   = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  noc_flit_pkg::flit_t gen_flit,
    input  logic                gen_valid,
    output logic                gen_full,
    output noc_flit_pkg::flit_t inject_flit,
    output logic                inject_valid,
    input  logic                inject_credit
);
    import noc_flit_pkg::*;

    localparam int aw  = (inject_depth > 1) ? $clog2(inject_depth) : 1;
    localparam int cw  = $clog2(inject_depth + 1);
    localparam int crw = $clog2(inject_credits + 1);

    flit_t          mem [inject_depth];
    logic [aw-1:0]  wr_ptr;
    logic [aw-1:0]  rd_ptr;
    logic [cw-1:0]  count;
    logic [crw-1:0] credit_cnt;  // free slots in the router input buffer
    logic           send;

    // one slot of slack covers the flit already on its way from the source
    assign gen_full     = (count >= cw'(inject_depth - 1));
    assign inject_valid = (count != '0) && (credit_cnt != '0);
    assign inject_flit  = mem[rd_ptr];
    assign send         = inject_valid;

    always_ff @(posedge clk) begin
        if (gen_valid) begin
            mem[wr_ptr] <= gen_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= crw'(inject_credits);
        end else begin
            if (gen_valid) begin
                wr_ptr <= (wr_ptr == aw'(inject_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == aw'(inject_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({gen_valid, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case ({send, inject_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: ;  // spend and return cancel
            endcase
        end
    end

    // router never returns more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= crw'(inject_credits));

    // spending the last credit blocks the link until one comes back
    a_no_send_at_zero: assert property (@(posedge clk) disable iff (rst)
        (send && credit_cnt == crw'(1) && !inject_credit) |=> !inject_valid);

    // source honours gen_full in spite of its registered output
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        gen_valid |-> (count != cw'(inject_depth)));

endmodule

/* logic/packet_source.sv */
`timescale 1ns/100ps

module packet_source #(
    parameter noc_flit_pkg::coord_t  cur_x         = 3'd0,
    parameter noc_flit_pkg::coord_t  cur_y         = 3'd0,
    parameter noc_flit_pkg::coord_t  cur_z         = 3'd0,
    parameter traffic_pkg::pattern_t pattern       = traffic_pkg::nearest,
    parameter int                    packet_size   = 4,
    parameter int                    packet_num    = 6,
    parameter int                    injection_gap = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                gen_full,
    output noc_flit_pkg::flit_t gen_flit,
    output logic                gen_valid,
    output traffic_pkg::cnt_t   sent_count,
    output logic                src_done
);
    import noc_flit_pkg::*;
    import traffic_pkg::*;

    localparam int fw = $clog2(packet_size + 1);
    localparam int gw = $clog2(injection_gap + 2);

    localparam coord_t nxt_x = ring_next(cur_x, XSIZE);
    localparam coord_t nxt_y = ring_next(cur_y, YSIZE);
    localparam coord_t nxt_z = ring_next(cur_z, ZSIZE);

    logic [fw-1:0] flit_cnt;   // flits of the current packet already issued
    logic [gw-1:0] gap_cnt;
    logic          advance;
    flit_t         next_flit;

    assign src_done = (sent_count == cnt_t'(packet_num));
    assign advance  = (sent_count < cnt_t'(packet_num)) && (gap_cnt == '0) && !gen_full;

    always_comb begin
        next_flit = '0;
        if (flit_cnt == '0) begin
            if (packet_size == 1) begin
                next_flit.kind = single;
            end else begin
                next_flit.kind = head;
            end
            next_flit.dir_neg = 1'b0;  // always leaves on x-positive
            next_flit.dst_x   = nxt_x;
            next_flit.dst_y   = (pattern == diag3) ? nxt_y : cur_y;
            next_flit.dst_z   = (pattern == diag3) ? nxt_z : cur_z;
            next_flit.hops    = (pattern == diag3) ? 4'd3 : 4'd1;
            next_flit.src_x   = cur_x;
            next_flit.src_y   = cur_y;
            next_flit.src_z   = cur_z;
            next_flit.seq     = sent_count[6:0];
        end else if (flit_cnt == fw'(packet_size - 1)) begin
            next_flit.kind = tail;
        end else begin
            next_flit.kind = body;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flit_cnt   <= '0;
            gap_cnt    <= '0;
            sent_count <= '0;
            gen_valid  <= 1'b0;
        end else begin
            gen_valid <= advance;
            if (advance) begin
                if (flit_cnt == fw'(packet_size - 1)) begin
                    flit_cnt   <= '0;
                    sent_count <= sent_count + 1'b1;
                    gap_cnt    <= gw'(injection_gap);  // idle cycles before next head
                end else begin
                    flit_cnt <= flit_cnt + 1'b1;
                end
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            gen_flit <= next_flit;
        end
    end

    // a new burst of flits never starts against a full queue
    a_no_issue_when_full: assert property (@(posedge clk) disable iff (rst)
        $rose(gen_valid) |-> !gen_full);

endmodule

/* logic/traffic_pkg.sv */
package traffic_pkg;

    // destination pattern of the generated packets
    typedef enum logic {
        nearest = 1'b0,  // next node on the x ring in one hop
        diag3   = 1'b1   // next node on all three rings in three hops
    } pattern_t;

    // first framing error seen on the eject stream
    typedef enum logic [1:0] {
        none         = 2'b00,
        flit_wrong   = 2'b01,
        flit_missing = 2'b10,
        flit_timeout = 2'b11
    } check_err_t;

    typedef logic [15:0] cnt_t;

endpackage

/* logic/noc_flit_pkg.sv */
package noc_flit_pkg;

    // one coordinate on a torus ring
    typedef logic [2:0] coord_t;

    // ring sizes of the 4x4x4 torus
    localparam int XSIZE = 4;
    localparam int YSIZE = 4;
    localparam int ZSIZE = 4;

    typedef enum logic [1:0] {
        head   = 2'b00,
        body   = 2'b01,
        tail   = 2'b10,
        single = 2'b11
    } flit_kind_t;

    // header layout with the msb first
    // body and tail flits carry only the kind and zero elsewhere
    typedef struct packed {
        flit_kind_t kind;
        logic       dir_neg;  // set when the packet leaves on a negative port
        coord_t     dst_z;
        coord_t     dst_y;
        coord_t     dst_x;
        logic [3:0] hops;
        coord_t     src_z;
        coord_t     src_y;
        coord_t     src_x;
        logic [6:0] seq;      // packet index at the source
    } flit_t;

    // next position on a ring with wraparound
    function automatic coord_t ring_next(coord_t c, int size);
        if (int'(c) < size - 1) begin
            return c + 3'd1;
        end
        return '0;
    endfunction

endpackage
